/* project.f */
hdl/cpu_pkg.sv
hdl/fetch_queue.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/output_port.sv
hdl/cpu_top.sv
test/cpu_assert.sv
test/cpu_checker.sv
test/tb_top.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_top with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_top -f project.f -Mdir obj_dir
	./obj_dir/Vtb_top > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_top.sv */
`timescale 1ns/1ns

module tb_top;

    localparam int TOTAL_INSTR = 4 + 16 + 28 + 20 + 28;  // reset, ldi, alu, in, backpressure
    localparam int TIMEOUT     = 20 * TOTAL_INSTR + 200;

    logic            clk         = 1'b0;
    logic            rst         = 1'b1;
    logic            instr_valid = 1'b0;
    cpu_pkg::instr_t instr_data  = '0;
    logic            instr_credit;
    cpu_pkg::word_t  in_port     = '0;
    logic            out_valid;
    cpu_pkg::word_t  out_data;
    logic            out_credit  = 1'b0;

    int         seed          = 32'h78b16dfb;
    logic [7:0] send_q [$];                          // bytes waiting for a credit
    int         send_credits  = 0;
    int         gap_pct       = 25;                  // chance of an idle cycle
    int         credit_delay  = 3;                   // max wait before a credit goes back
    int         owed          = 0;                   // output credits not yet returned
    int         hold          = 0;
    int         outs_expected = 0;
    int         outs_received = 0;
    int         cycle_count   = 0;
    logic [1:0] last_dest     = 2'd0;                // target of the newest instruction
    logic [3:0] alu_ops [10]  = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd10, 4'd11};

    initial begin
        forever #4 clk = ~clk;                       // 8 ns period
    end

    cpu_top cpu_top_inst (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_data   (instr_data),
        .instr_credit (instr_credit),
        .in_port      (in_port),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_credit   (out_credit)
    );

    cpu_checker checker_inst (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_byte  (instr_data),
        .in_port     (in_port),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    bind cpu_top cpu_assert cpu_assert_inst (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_credit (instr_credit),
        .out_valid    (out_valid),
        .out_credit   (out_credit),
        .out_data     (out_data)
    );

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [7:0] gen_ldi();
        logic [1:0] rd;
        rd = 2'(rand_below(4));
        last_dest = rd;
        return {2'b11, rd, 4'(rand_below(16))};
    endfunction

    function automatic logic [7:0] gen_alu();
        logic [3:0] op;
        logic [1:0] ra;
        logic [1:0] rb;
        op = alu_ops[rand_below(10)];
        ra = 2'(rand_below(4));
        rb = 2'(rand_below(4));
        if (rand_below(4) != 0) rb = last_dest;      // mostly read the last result
        if (rand_below(2) == 0) ra = last_dest;
        last_dest = ra;
        return {op, ra, rb};
    endfunction

    function automatic logic [7:0] gen_in();
        logic [1:0] ra;
        ra = 2'(rand_below(4));
        last_dest = ra;
        return {4'd8, ra, 2'd0};
    endfunction

    task automatic push_instr(input logic [7:0] ins);
        send_q.push_back(ins);
        if (ins[7:4] == 4'd9) outs_expected++;       // one output per OUT
    endtask

    task automatic push_out_sequence();
        for (int r = 0; r < 4; r++) begin
            push_instr({4'd9, 2'd0, 2'(r)});
        end
    endtask

    task automatic finish_test();
        while (outs_received < outs_expected) @(posedge clk);
        @(posedge clk);                              // checker has seen the last output
        checker_inst.end_test();
    endtask

    // sender side of the instruction credit loop
    always @(posedge clk) begin
        if (rst) begin
            instr_valid  <= 1'b0;
            send_credits = cpu_pkg::FETCH_DEPTH;
        end else begin
            if (instr_credit) send_credits++;
            if (send_q.size() != 0 && send_credits > 0 && rand_below(100) >= gap_pct) begin
                instr_valid <= 1'b1;
                instr_data  <= send_q.pop_front();
                send_credits--;
            end else begin
                instr_valid <= 1'b0;
            end
        end
    end

    // consumer returns each credit after a random wait
    always @(posedge clk) begin
        if (rst) begin
            out_credit <= 1'b0;
            owed = 0;
            hold = 0;
        end else begin
            if (out_valid) begin
                owed++;
                outs_received++;
            end
            if (owed > 0 && hold == 0) begin
                out_credit <= 1'b1;
                owed--;
                hold = rand_below(credit_delay + 1);
            end else begin
                out_credit <= 1'b0;
                if (owed > 0) hold--;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT) begin
            $display("timeout: run stopped after %0d cycles with outputs still missing", TIMEOUT);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int sel;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        checker_inst.begin_test("reset_state");
        push_out_sequence();                         // all regs still zero
        finish_test();

        checker_inst.begin_test("ldi_out");
        repeat (12) push_instr(gen_ldi());
        push_out_sequence();
        finish_test();

        checker_inst.begin_test("alu_forwarding");
        gap_pct = 0;                                 // back to back issue
        repeat (24) push_instr(gen_alu());
        push_out_sequence();
        finish_test();

        gap_pct = 25;
        in_port <= 8'(rand_below(256));              // held for the whole test
        @(posedge clk);
        checker_inst.begin_test("in_port_read");
        repeat (16) begin
            if (rand_below(5) < 2) begin
                push_instr(gen_in());
            end else begin
                push_instr(gen_alu());
            end
        end
        push_out_sequence();
        finish_test();

        checker_inst.begin_test("backpressure");
        gap_pct      = 0;
        credit_delay = 40;                           // long credit droughts
        repeat (3) begin
            repeat (8) begin
                sel = rand_below(10);
                if (sel < 3) begin
                    push_instr({4'd9, 2'd0, 2'(rand_below(4))});
                end else if (sel < 6) begin
                    push_instr(gen_ldi());
                end else begin
                    push_instr(gen_alu());
                end
            end
            while (send_q.size() != 0) @(posedge clk);
            repeat (rand_below(10) + 1) @(posedge clk); // idle between bursts
        end
        push_out_sequence();
        finish_test();

        checker_inst.report_totals();
        if (checker_inst.total_errors == 0 && cpu_top_inst.cpu_assert_inst.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* test/cpu_checker.sv */
`timescale 1ns/1ns

module cpu_checker (
    input logic           clk,
    input logic           rst,
    input logic           instr_valid,
    input logic [7:0]     instr_byte,            // raw instruction byte
    input cpu_pkg::word_t in_port,
    input logic           out_valid,
    input cpu_pkg::word_t out_data
);

    cpu_pkg::word_t model_regs [4];
    cpu_pkg::word_t expect_q [$];                // predicted OUT bytes in order
    string          test_name    = "startup";
    int             test_errors  = 0;
    int             test_outputs = 0;
    int             total_errors = 0;
    int             tests_run    = 0;
    int             tests_failed = 0;
    int             outs_checked = 0;

    // instruction set model applied at acceptance
    task automatic execute_instr(input logic [7:0] ins);
        logic [1:0] a;
        logic [1:0] b;
        a = ins[3:2];
        b = ins[1:0];
        if (ins[7:6] == 2'b11) begin
            model_regs[ins[5:4]] = {4'h0, ins[3:0]}; // ldi zero extends imm
        end else begin
            case (ins[7:4])
                4'd1:    model_regs[a] = model_regs[b];
                4'd2:    model_regs[a] = model_regs[a] + model_regs[b]; // wraps
                4'd3:    model_regs[a] = model_regs[a] - model_regs[b];
                4'd4:    model_regs[a] = model_regs[a] & model_regs[b];
                4'd5:    model_regs[a] = model_regs[a] | model_regs[b];
                4'd6:    model_regs[a] = ~model_regs[b];
                4'd7:    model_regs[a] = model_regs[a] + 8'd1;
                4'd8:    model_regs[a] = in_port;    // held constant per test
                4'd9:    expect_q.push_back(model_regs[b]);
                default: ;                           // nop, 10, 11
            endcase
        end
    endtask

    task automatic compare_output();
        cpu_pkg::word_t exp;
        if (expect_q.size() == 0) begin
            $display("error in %s: output 0x%02h arrived with no OUT outstanding",
                     test_name, out_data);
            test_errors++;
        end else begin
            exp = expect_q.pop_front();
            test_outputs++;
            if (out_data !== exp) begin
                $display("mismatch in %s: expected 0x%02h, actual 0x%02h",
                         test_name, exp, out_data);
                test_errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            foreach (model_regs[i]) model_regs[i] = '0;
            expect_q.delete();
        end else begin
            if (out_valid) compare_output();     // before this cycle's instruction
            if (instr_valid) execute_instr(instr_byte);
        end
    end

    task automatic begin_test(input string name);
        test_name = name;
    endtask

    task automatic end_test();
        if (expect_q.size() != 0) begin
            $display("error in %s: %0d expected outputs never arrived",
                     test_name, expect_q.size());
            test_errors++;
            expect_q.delete();
        end
        tests_run++;
        total_errors += test_errors;
        outs_checked += test_outputs;
        if (test_errors == 0) begin
            $display("test %s: pass, %0d outputs checked", test_name, test_outputs);
        end else begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", test_name, test_errors);
        end
        test_errors  = 0;                        // stray errors go to the next test
        test_outputs = 0;
    endtask

    task automatic report_totals();
        $display("tests run %0d, failed %0d, outputs checked %0d, errors %0d",
                 tests_run, tests_failed, outs_checked, total_errors);
    endtask

endmodule

/* test/cpu_assert.sv */
`timescale 1ns/1ns

module cpu_assert (
    input logic           clk,
    input logic           rst,
    input logic           instr_valid,
    input logic           instr_credit,
    input logic           out_valid,
    input logic           out_credit,
    input cpu_pkg::word_t out_data
);

    int outs_sent      = 0;                      // out_valid cycles so far
    int outs_returned  = 0;                      // out_credit pulses so far
    int instr_taken    = 0;
    int instr_returned = 0;
    int fail_count     = 0;

    always @(posedge clk) begin
        if (rst) begin
            outs_sent      <= 0;
            outs_returned  <= 0;
            instr_taken    <= 0;
            instr_returned <= 0;
        end else begin
            if (out_valid)    outs_sent      <= outs_sent + 1;
            if (out_credit)   outs_returned  <= outs_returned + 1;
            if (instr_valid)  instr_taken    <= instr_taken + 1;
            if (instr_credit) instr_returned <= instr_returned + 1;
        end
    end

    out_needs_credit: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (outs_sent - outs_returned) < cpu_pkg::OUT_CREDITS)
        else begin
            $error("out_valid raised while every output credit was spent");
            fail_count++;
        end

    credit_after_accept: assert property (@(posedge clk) disable iff (rst)
        instr_credit |-> instr_returned < instr_taken)
        else begin
            $error("instr_credit returned more credits than instructions accepted");
            fail_count++;
        end

    out_data_known: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(out_data))
        else begin
            $error("out_data has unknown bits while out_valid is high");
            fail_count++;
        end

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,            // only sent while a credit is held
    input  cpu_pkg::instr_t instr_data,
    output logic            instr_credit,           // one credit back per pulse
    input  cpu_pkg::word_t  in_port,
    output logic            out_valid,
    output cpu_pkg::word_t  out_data,
    input  logic            out_credit              // consumer returns one output credit
);

    cpu_pkg::instr_t   head;                        // queue head to decode
    logic              not_empty;
    logic              pop;
    logic              credit_avail;                // output credit held
    logic              out_issue;                   // OUT leaving decode
    cpu_pkg::reg_idx_t ra_idx;
    cpu_pkg::reg_idx_t rb_idx;
    cpu_pkg::word_t    ra_val;
    cpu_pkg::word_t    rb_val;
    cpu_pkg::id_ex_t   id_ex;
    cpu_pkg::ex_wb_t   ex_wb;                       // shared by rf write and output port

    fetch_queue fetch_queue_inst (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_data   (instr_data),
        .pop          (pop),
        .head         (head),
        .not_empty    (not_empty),
        .instr_credit (instr_credit)
    );

    decode_stage decode_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .head         (head),
        .not_empty    (not_empty),
        .pop          (pop),
        .credit_avail (credit_avail),
        .out_issue    (out_issue),
        .in_port      (in_port),
        .ra_idx       (ra_idx),
        .rb_idx       (rb_idx),
        .ra_val       (ra_val),
        .rb_val       (rb_val),
        .id_ex        (id_ex)
    );

    register_file register_file_inst (
        .clk    (clk),
        .rst    (rst),
        .ra_idx (ra_idx),
        .rb_idx (rb_idx),
        .ra_val (ra_val),
        .rb_val (rb_val),
        .ex_wb  (ex_wb)
    );

    execute_stage execute_stage_inst (
        .clk   (clk),
        .rst   (rst),
        .id_ex (id_ex),
        .ex_wb (ex_wb)
    );

    output_port output_port_inst (
        .clk          (clk),
        .rst          (rst),
        .out_issue    (out_issue),
        .out_credit   (out_credit),
        .ex_wb        (ex_wb),
        .credit_avail (credit_avail),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

endmodule

/* hdl/output_port.sv */
`timescale 1ns/1ns

module output_port (
    input  logic            clk,
    input  logic            rst,
    input  logic            out_issue,              // credit spent at issue
    input  logic            out_credit,             // credit back from consumer
    input  cpu_pkg::ex_wb_t ex_wb,
    output logic            credit_avail,
    output logic            out_valid,
    output cpu_pkg::word_t  out_data
);

    logic [cpu_pkg::CREDIT_W-1:0] credits;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= cpu_pkg::CREDIT_W'(cpu_pkg::OUT_CREDITS);
        end else begin
            case ({out_issue, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;        // spend and return cancel
            endcase
        end
    end

    assign credit_avail = (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= ex_wb.valid && ex_wb.is_out;
        end
        out_data <= ex_wb.out_val;                  // qualified by out_valid
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic            clk,
    input  logic            rst,
    input  cpu_pkg::id_ex_t id_ex,
    output cpu_pkg::ex_wb_t ex_wb
);

    logic           wb_write;                       // ex_wb holds a live reg write
    logic           fwd_a;
    logic           fwd_b;
    cpu_pkg::word_t op_a;
    cpu_pkg::word_t rb_fwd;                         // forwarded rb, also OUT data
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_res;

    assign wb_write = ex_wb.valid && ex_wb.reg_write;

    // IN keeps its port sample in ra_val
    assign fwd_a = wb_write && (ex_wb.dest == id_ex.ra_idx)
                   && (id_ex.ctrl.alu_op != cpu_pkg::OP_IN);
    assign fwd_b = wb_write && (ex_wb.dest == id_ex.rb_idx);

    assign op_a   = fwd_a ? ex_wb.result : id_ex.ra_val;
    assign rb_fwd = fwd_b ? ex_wb.result : id_ex.rb_val;
    assign op_b   = id_ex.ctrl.use_imm ? cpu_pkg::word_t'(id_ex.ctrl.imm) : rb_fwd; // zero ext

    always_comb begin
        case (id_ex.ctrl.alu_op)
            cpu_pkg::OP_MOV: alu_res = op_b;
            cpu_pkg::OP_ADD: alu_res = op_a + op_b; // wraps mod 256
            cpu_pkg::OP_SUB: alu_res = op_a - op_b;
            cpu_pkg::OP_AND: alu_res = op_a & op_b;
            cpu_pkg::OP_OR:  alu_res = op_a | op_b;
            cpu_pkg::OP_NOT: alu_res = ~op_b;
            cpu_pkg::OP_INC: alu_res = op_a + 1'b1;
            cpu_pkg::OP_IN:  alu_res = op_a;        // sampled port value
            cpu_pkg::OP_LDI: alu_res = op_b;        // imm already selected
            default:         alu_res = '0;          // nop, out
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_wb.valid <= 1'b0;
        end else begin
            ex_wb.valid <= id_ex.valid;             // no stall here
        end
        ex_wb.reg_write <= id_ex.ctrl.reg_write;
        ex_wb.dest      <= id_ex.ctrl.dest;
        ex_wb.result    <= alu_res;
        ex_wb.is_out    <= id_ex.ctrl.is_out;
        ex_wb.out_val   <= rb_fwd;
    end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t ra_idx,
    input  cpu_pkg::reg_idx_t rb_idx,
    output cpu_pkg::word_t    ra_val,
    output cpu_pkg::word_t    rb_val,
    input  cpu_pkg::ex_wb_t   ex_wb                 // write port
);

    cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];
    logic           wr_en;

    assign wr_en = ex_wb.valid && ex_wb.reg_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};                 // all regs start at zero
        end else if (wr_en) begin
            regs[ex_wb.dest] <= ex_wb.result;
        end
    end

    // write-through so decode sees this cycle's writeback
    assign ra_val = (wr_en && ex_wb.dest == ra_idx) ? ex_wb.result : regs[ra_idx];
    assign rb_val = (wr_en && ex_wb.dest == rb_idx) ? ex_wb.result : regs[rb_idx];

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::instr_t   head,
    input  logic              not_empty,
    output logic              pop,
    input  logic              credit_avail,
    output logic              out_issue,
    input  cpu_pkg::word_t    in_port,
    output cpu_pkg::reg_idx_t ra_idx,
    output cpu_pkg::reg_idx_t rb_idx,
    input  cpu_pkg::word_t    ra_val,
    input  cpu_pkg::word_t    rb_val,
    output cpu_pkg::id_ex_t   id_ex
);

    cpu_pkg::ex_ctrl_t ctrl;
    logic              is_imm;                      // ldi form
    logic              is_out_op;
    logic              is_in_op;
    logic              issue;

    assign is_imm    = (head.imm_form.prefix == cpu_pkg::IMM_PREFIX);
    assign is_out_op = !is_imm && (head.reg_form.opcode == cpu_pkg::OP_OUT);
    assign is_in_op  = !is_imm && (head.reg_form.opcode == cpu_pkg::OP_IN);

    always_comb begin
        ctrl = '0;
        if (is_imm) begin
            ctrl.alu_op    = cpu_pkg::OP_LDI;
            ctrl.use_imm   = 1'b1;
            ctrl.imm       = head.imm_form.imm;
            ctrl.reg_write = 1'b1;
            ctrl.dest      = head.imm_form.rd;
        end else begin
            ctrl.alu_op = head.reg_form.opcode;
            ctrl.dest   = head.reg_form.ra;         // ra is always the target
            case (head.reg_form.opcode)
                cpu_pkg::OP_MOV, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
                cpu_pkg::OP_OR,  cpu_pkg::OP_NOT, cpu_pkg::OP_INC, cpu_pkg::OP_IN: begin
                    ctrl.reg_write = 1'b1;
                end
                cpu_pkg::OP_OUT: ctrl.is_out = 1'b1;
                default: ctrl.alu_op = cpu_pkg::OP_NOP; // nop and codes 10/11
            endcase
        end
    end

    // OUT waits at the head until an output credit is free
    assign issue     = not_empty && (!is_out_op || credit_avail);
    assign pop       = issue;
    assign out_issue = issue && is_out_op;

    assign ra_idx = head.reg_form.ra;               // ldi ignores this read
    assign rb_idx = head.reg_form.rb;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= issue;                   // bubble when stalled or empty
        end
        id_ex.ctrl   <= ctrl;
        id_ex.ra_idx <= ra_idx;
        id_ex.rb_idx <= rb_idx;
        id_ex.ra_val <= is_in_op ? in_port : ra_val; // port sample rides in ra_val
        id_ex.rb_val <= rb_val;
    end

endmodule

/* hdl/fetch_queue.sv */
`timescale 1ns/1ns

module fetch_queue (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  cpu_pkg::instr_t instr_data,
    input  logic            pop,                    // decode took the head
    output cpu_pkg::instr_t head,
    output logic            not_empty,
    output logic            instr_credit
);

    localparam int PTR_W = $clog2(cpu_pkg::FETCH_DEPTH);
    localparam int CNT_W = $clog2(cpu_pkg::FETCH_DEPTH + 1);

    cpu_pkg::instr_t   mem [cpu_pkg::FETCH_DEPTH];  // instruction slots
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            mem[wr_ptr] <= instr_data;              // credits guarantee a free slot
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (instr_valid) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (pop)         rd_ptr <= rd_ptr + 1'b1;
            case ({instr_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // both or neither
            endcase
        end
    end

    assign head         = mem[rd_ptr];
    assign not_empty    = (count != '0);
    assign instr_credit = pop;                      // slot freed this cycle

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN        = 8;                   // data path width
    localparam int NUM_REGS    = 4;                   // r0..r3
    localparam int IMM_W       = 4;                   // immediate field width
    localparam int FETCH_DEPTH = 4;                   // queue slots == sender credits at reset
    localparam int OUT_CREDITS = 2;                   // output credits held after reset
    localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1); // counter holds 0..OUT_CREDITS

    localparam logic [1:0] IMM_PREFIX = 2'b11;        // top bits selecting the LDI form

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_MOV   = 4'd1,                              // ra <- rb
        OP_ADD   = 4'd2,                              // ra <- ra + rb
        OP_SUB   = 4'd3,                              // ra <- ra - rb
        OP_AND   = 4'd4,
        OP_OR    = 4'd5,
        OP_NOT   = 4'd6,                              // ra <- ~rb
        OP_INC   = 4'd7,                              // ra <- ra + 1
        OP_IN    = 4'd8,                              // ra <- in_port
        OP_OUT   = 4'd9,                              // out_port <- rb
        OP_RSV_A = 4'd10,                             // treated as nop
        OP_RSV_B = 4'd11,                             // treated as nop
        OP_LDI   = 4'd12                              // 12..15 all decode as ldi
    } opcode_t;

    typedef struct packed {
        opcode_t  opcode;                             // bits 7:4
        reg_idx_t ra;                                 // bits 3:2, also dest
        reg_idx_t rb;                                 // bits 1:0
    } reg_form_t;

    typedef struct packed {
        logic [1:0]       prefix;                     // 2'b11 for ldi
        reg_idx_t         rd;
        logic [IMM_W-1:0] imm;                        // zero extended on load
    } imm_form_t;

    // one byte decoded as either form
    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } instr_t;

    typedef struct packed {
        opcode_t          alu_op;
        logic             use_imm;                    // operand b from imm
        logic [IMM_W-1:0] imm;
        logic             reg_write;
        reg_idx_t         dest;
        logic             is_out;
    } ex_ctrl_t;

    typedef struct packed {
        logic     valid;                              // low == bubble
        ex_ctrl_t ctrl;
        reg_idx_t ra_idx;
        reg_idx_t rb_idx;
        word_t    ra_val;                             // in_port sample for IN
        word_t    rb_val;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t dest;
        word_t    result;
        logic     is_out;
        word_t    out_val;                            // rb value for OUT
    } ex_wb_t;

endpackage
